// ==== vp_defs.svh ====
`ifndef VP_DEFS_SVH
`define VP_DEFS_SVH

// coordinate widths, enough for a 2048 x 2048 raster
`define VP_X_W 11
`define VP_Y_W 11

// vin_* to vp_* latency in clk cycles
// locator 1 + crop 1 + colour 2
`define VP_LATENCY 4

// luma weights in 1/256 units, they add up to exactly 256
// so a white pixel stays at 255 after the divide
`define VP_GRAY_R 77
`define VP_GRAY_G 150
`define VP_GRAY_B 29

`endif

// ==== vp_pkg.sv ====
`default_nettype none

`include "vp_defs.svh"

package vp_pkg;

    // RGB565 word as it arrives on vin_data
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // expanded pixel used inside the colour pipeline
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // raster position, column and row
    typedef logic [`VP_X_W-1:0] xcoord_t;
    typedef logic [`VP_Y_W-1:0] ycoord_t;

    // colour algorithm select
    typedef enum logic {
        ALGO_BYPASS = 1'b0,
        ALGO_GRAY   = 1'b1
    } algo_t;

endpackage

`default_nettype wire

// ==== pixel_delay.sv ====
`default_nettype none

module pixel_delay import vp_pkg::*; #(
    parameter type T     = rgb565_t,
    parameter int  DEPTH = 1
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic in_valid,
    input  wire T     in_data,
    output logic      out_valid,
    output T          out_data
);

    // valid chain, cleared by reset
    logic [DEPTH-1:0] valid_q;
    // payload chain, no reset needed
    T                 data_q [DEPTH];
    // edges seen since reset release, saturates at DEPTH
    int unsigned      fill_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            fill_q  <= 0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
            if (fill_q < DEPTH) begin
                fill_q <= fill_q + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

    // once the chain has been refilled after reset, the output is the input DEPTH edges ago
    a_valid_delay : assert property (@(posedge clk) disable iff (!rst_n)
        (fill_q == DEPTH) |-> (out_valid == $past(in_valid, DEPTH)));

endmodule

`default_nettype wire

// ==== pixel_locator.sv ====
`default_nettype none

module pixel_locator import vp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    vs,
    input  wire logic    de,
    output logic         loc_de,
    output xcoord_t      x,
    output ycoord_t      y
);

    // running column, counts enabled pixels in the current line
    xcoord_t x_cnt;
    // running row, counts finished lines since vs dropped
    ycoord_t y_cnt;
    // de from the previous cycle, for the falling edge
    logic    de_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt  <= '0;
            y_cnt  <= '0;
            de_q   <= 1'b0;
            loc_de <= 1'b0;
            x      <= '0;
            y      <= '0;
        end else begin
            de_q <= de;

            // outputs carry the position of the pixel sampled on this edge
            // pixels during vertical blanking are dropped
            loc_de <= de && !vs;
            x      <= x_cnt;
            y      <= y_cnt;

            if (vs) begin
                // blanking, restart the raster
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (de) begin
                x_cnt <= x_cnt + 1'b1;
            end else if (de_q) begin
                // end of line, next line starts at column 0
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // a pixel inside a line always leaves the column count above zero,
    // a zero here means the counter ran past its top value
    a_x_no_wrap : assert property (@(posedge clk) disable iff (!rst_n)
        (de && !vs) |=> (x_cnt != '0));

endmodule

`default_nettype wire

// ==== crop_decimator.sv ====
`default_nettype none

module crop_decimator import vp_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       in_de,
    input  wire xcoord_t    x,
    input  wire ycoord_t    y,
    input  wire rgb565_t    in_data,
    input  wire xcoord_t    start_x,
    input  wire xcoord_t    end_x,
    input  wire ycoord_t    start_y,
    input  wire ycoord_t    end_y,
    input  wire logic [1:0] shift_x,
    input  wire logic [1:0] shift_y,
    output logic            out_de,
    output rgb565_t         out_data
);

    localparam xcoord_t X_ONES = '1;
    localparam ycoord_t Y_ONES = '1;

    // position relative to the window corner
    xcoord_t off_x;
    ycoord_t off_y;
    // low shift bits set, selects the bits that must be zero on the grid
    xcoord_t mask_x;
    ycoord_t mask_y;
    logic    in_win_x;
    logic    in_win_y;
    logic    on_grid_x;
    logic    on_grid_y;
    logic    keep;

    always_comb begin
        off_x  = x - start_x;
        off_y  = y - start_y;
        mask_x = ~(X_ONES << shift_x);
        mask_y = ~(Y_ONES << shift_y);

        // window is half open, end is excluded
        in_win_x = (x >= start_x) && (x < end_x);
        in_win_y = (y >= start_y) && (y < end_y);

        // decimation grid is anchored on the window corner
        on_grid_x = (off_x & mask_x) == '0;
        on_grid_y = (off_y & mask_y) == '0;

        keep = in_de && in_win_x && in_win_y && on_grid_x && on_grid_y;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_de <= 1'b0;
        end else begin
            out_de <= keep;
        end
    end

    // pixel word only matters when out_de is high
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

    // every kept pixel came from inside the window one cycle back
    a_kept_in_window : assert property (@(posedge clk) disable iff (!rst_n)
        out_de |-> ($past(x) >= $past(start_x) && $past(x) < $past(end_x) &&
                    $past(y) >= $past(start_y) && $past(y) < $past(end_y)));

endmodule

`default_nettype wire

// ==== color_proc.sv ====
`default_nettype none

`include "vp_defs.svh"

module color_proc import vp_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    in_de,
    input  wire rgb565_t in_data,
    input  wire algo_t   algorithm_sel,
    output logic         out_de,
    output rgb565_t      out_data
);

    // expanded input, bit replication fills the low bits
    rgb888_t px;

    // stage 1 registers
    logic    s1_de;
    algo_t   s1_algo;
    rgb888_t s1_px;
    logic [15:0] s1_pr;
    logic [15:0] s1_pg;
    logic [15:0] s1_pb;

    // stage 2 combinational
    // weights add to 256, so the sum stays below 2^16
    logic [15:0] sum;
    logic [7:0]  gray;

    always_comb begin
        px.r = {in_data.r, in_data.r[4:2]};
        px.g = {in_data.g, in_data.g[5:4]};
        px.b = {in_data.b, in_data.b[4:2]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_de <= 1'b0;
        end else begin
            s1_de <= in_de;
        end
    end

    // select travels with the pixel, so a change takes effect per pixel
    always_ff @(posedge clk) begin
        s1_algo <= algorithm_sel;
        s1_px   <= px;
        s1_pr   <= 16'(px.r) * 16'(`VP_GRAY_R);
        s1_pg   <= 16'(px.g) * 16'(`VP_GRAY_G);
        s1_pb   <= 16'(px.b) * 16'(`VP_GRAY_B);
    end

    always_comb begin
        sum  = s1_pr + s1_pg + s1_pb;
        // divide by 256, truncated
        gray = sum[15:8];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_de <= 1'b0;
        end else begin
            out_de <= s1_de;
        end
    end

    // repack by truncation, bypass gives back the input word exactly
    always_ff @(posedge clk) begin
        if (s1_algo == ALGO_GRAY) begin
            out_data <= {gray[7:3], gray[7:2], gray[7:3]};
        end else begin
            out_data <= {s1_px.r[7:3], s1_px.g[7:2], s1_px.b[7:3]};
        end
    end

    // gray is a weighted mean of the expanded channels
    // and so lies between the smallest and the largest of them
    a_gray_range : assert property (@(posedge clk) disable iff (!rst_n)
        (s1_de && s1_algo == ALGO_GRAY) |->
            ((gray >= s1_px.r || gray >= s1_px.g || gray >= s1_px.b) &&
             (gray <= s1_px.r || gray <= s1_px.g || gray <= s1_px.b)));

endmodule

`default_nettype wire

// ==== video_proc.sv ====
`default_nettype none

`include "vp_defs.svh"

module video_proc import vp_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    // video in
    input  wire logic       vin_vs,
    input  wire logic       vin_de,
    input  wire rgb565_t    vin_data,

    // run time setup, hold steady while vin_vs is low
    input  wire xcoord_t    start_x,
    input  wire xcoord_t    end_x,
    input  wire ycoord_t    start_y,
    input  wire ycoord_t    end_y,
    input  wire logic [1:0] shift_x,
    input  wire logic [1:0] shift_y,
    input  wire algo_t      algorithm_sel,

    // processed video out
    output logic            vp_vs,
    output logic            vp_de,
    output rgb565_t         vp_data
);

    // locator stage
    logic    loc_de;
    xcoord_t loc_x;
    ycoord_t loc_y;
    rgb565_t loc_data;
    // crop stage
    logic    crop_de;
    rgb565_t crop_data;
    // delayed sync
    logic    vs_valid;
    logic    vs_data;

    pixel_locator i_pixel_locator (
        .clk    (clk),
        .rst_n  (rst_n),
        .vs     (vin_vs),
        .de     (vin_de),
        .loc_de (loc_de),
        .x      (loc_x),
        .y      (loc_y)
    );

    // pixel word lined up with the registered coordinates
    pixel_delay #(
        .T     (rgb565_t),
        .DEPTH (1)
    ) i_data_delay (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (vin_de),
        .in_data   (vin_data),
        .out_valid (),
        .out_data  (loc_data)
    );

    crop_decimator i_crop_decimator (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_de    (loc_de),
        .x        (loc_x),
        .y        (loc_y),
        .in_data  (loc_data),
        .start_x  (start_x),
        .end_x    (end_x),
        .start_y  (start_y),
        .end_y    (end_y),
        .shift_x  (shift_x),
        .shift_y  (shift_y),
        .out_de   (crop_de),
        .out_data (crop_data)
    );

    color_proc i_color_proc (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_de         (crop_de),
        .in_data       (crop_data),
        .algorithm_sel (algorithm_sel),
        .out_de        (vp_de),
        .out_data      (vp_data)
    );

    // vs follows the same latency as the pixels
    pixel_delay #(
        .T     (logic),
        .DEPTH (`VP_LATENCY)
    ) i_vs_delay (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (1'b1),
        .in_data   (vin_vs),
        .out_valid (vs_valid),
        .out_data  (vs_data)
    );

    // valid stays low until the sync chain has refilled after reset
    assign vp_vs = vs_valid && vs_data;

endmodule

`default_nettype wire

// ==== vp_checker.sv ====
`default_nettype none

`include "vp_defs.svh"

module vp_checker import vp_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [8*16-1:0] test_name,
    // model side, valid in the cycle the pixel enters the DUT
    input  wire logic            vin_vs,
    input  wire logic            exp_de,
    input  wire rgb565_t         exp_data,
    // DUT outputs
    input  wire logic            vp_vs,
    input  wire logic            vp_de,
    input  wire rgb565_t         vp_data,
    output int                   errors,
    output int                   pending
);

    localparam int LAT = `VP_LATENCY;

    // expected pixels in raster order, with the cycle they went in
    rgb565_t exp_q[$];
    int      stamp_q[$];
    // vin_vs of the last LAT cycles, oldest first
    logic    vs_hist[$];
    int      err_cnt = 0;
    int      pend_cnt = 0;
    int      cycle = 0;
    logic    vs_prev = 1'b0;

    assign errors  = err_cnt;
    assign pending = pend_cnt;

    // falling edge sits halfway between DUT updates and new stimulus
    always @(negedge clk) begin
        rgb565_t exp_px;
        int      stamp;
        logic    exp_vs;
        if (!rst_n) begin
            if (vp_de !== 1'b0 || vp_vs !== 1'b0) begin
                $display("%0s: vp_de or vp_vs is high while reset is asserted", test_name);
                err_cnt++;
            end
            // whatever was in flight is lost by the reset
            exp_q.delete();
            stamp_q.delete();
            vs_hist.delete();
            vs_prev = 1'b0;
        end else begin
            cycle++;
            // sync chain refills for LAT cycles after reset, vp_vs stays low meanwhile
            exp_vs = 1'b0;
            if (vs_hist.size() == LAT) begin
                exp_vs = vs_hist.pop_front();
            end
            if (vp_vs !== exp_vs) begin
                $display("FAILED %0s vp_vs: expected %b, actual %b", test_name, exp_vs, vp_vs);
                err_cnt++;
            end
            vs_hist.push_back(vin_vs);

            if (vp_de === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("%0s: vp_de is high but no pixel was expected", test_name);
                    err_cnt++;
                end else begin
                    exp_px = exp_q.pop_front();
                    stamp  = stamp_q.pop_front();
                    if (vp_data !== exp_px) begin
                        $display("FAILED %0s vp_data: expected %h, actual %h",
                                 test_name, exp_px, vp_data);
                        err_cnt++;
                    end
                    if (cycle != stamp + LAT) begin
                        $display("FAILED %0s latency: expected cycle %0d, actual cycle %0d",
                                 test_name, stamp + LAT, cycle);
                        err_cnt++;
                    end
                end
            end else if (vp_de !== 1'b0) begin
                $display("%0s: vp_de is neither high nor low", test_name);
                err_cnt++;
            end

            // a new frame starts, the last one must be fully out by now
            if (vs_prev && !vin_vs && exp_q.size() != 0) begin
                $display("%0s: %0d pixels of the previous frame never came out",
                         test_name, exp_q.size());
                err_cnt++;
                exp_q.delete();
                stamp_q.delete();
            end
            vs_prev = vin_vs;

            if (exp_de) begin
                exp_q.push_back(exp_data);
                stamp_q.push_back(cycle);
            end
        end
        pend_cnt = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== tb_video_proc.sv ====
`default_nettype none

`include "vp_defs.svh"

module tb_video_proc import vp_pkg::*; ();

    localparam int FRAME_W      = 24;
    localparam int FRAME_H      = 12;
    localparam int LINE_CYCLES  = FRAME_W + 8;
    localparam int VS_CYCLES    = 2 * LINE_CYCLES;
    localparam int FRAME_CYCLES = VS_CYCLES + FRAME_H * LINE_CYCLES;
    localparam int FRAMES       = 4;
    localparam int NUM_TESTS    = 6;
    localparam int RESET_CYCLES = 8;
    // all full frames, one spare frame for the cut frame and resets, and a margin
    localparam int TIMEOUT = NUM_TESTS * FRAMES * FRAME_CYCLES + FRAME_CYCLES + 100;

    logic            clk = 1'b0;
    logic            rst_n = 1'b0;
    logic            vin_vs;
    logic            vin_de;
    rgb565_t         vin_data;
    xcoord_t         start_x;
    xcoord_t         end_x;
    ycoord_t         start_y;
    ycoord_t         end_y;
    logic [1:0]      shift_x;
    logic [1:0]      shift_y;
    algo_t           algorithm_sel;
    logic            vp_vs;
    logic            vp_de;
    rgb565_t         vp_data;
    // expected pixel, handed to the checker alongside the stimulus
    logic            exp_de;
    rgb565_t         exp_data;
    logic [8*16-1:0] test_name;
    int              errors;
    int              pending;
    // how the setup of the next frame is drawn
    bit              rand_window;
    bit              rand_shift;
    int              algo_mode;
    int              cycles;
    int              kept_count;
    int              failed_tests;
    int unsigned     seed_ret;

    video_proc i_video_proc (.*);

    vp_checker i_vp_checker (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // widen to 8 bits by repeating the top bits, grayscale, then truncate back
    function automatic rgb565_t model_pixel(input rgb565_t p, input algo_t algo);
        int      r8;
        int      g8;
        int      b8;
        int      gray;
        rgb565_t q;
        r8   = int'(p.r) * 8 + int'(p.r) / 4;
        g8   = int'(p.g) * 4 + int'(p.g) / 16;
        b8   = int'(p.b) * 8 + int'(p.b) / 4;
        gray = (`VP_GRAY_R * r8 + `VP_GRAY_G * g8 + `VP_GRAY_B * b8) / 256;
        if (algo == ALGO_GRAY) begin
            r8 = gray;
            g8 = gray;
            b8 = gray;
        end
        q.r = 5'(r8 / 8);
        q.g = 6'(g8 / 4);
        q.b = 5'(b8 / 8);
        return q;
    endfunction

    // inside the half open window and on the grid anchored at its corner
    function automatic logic is_kept(input int x, input int y);
        int sx;
        int sy;
        sx = int'(start_x);
        sy = int'(start_y);
        return x >= sx && x < int'(end_x) && y >= sy && y < int'(end_y) &&
               (x - sx) % (1 << shift_x) == 0 && (y - sy) % (1 << shift_y) == 0;
    endfunction

    task automatic drive(input logic vs, input logic de, input rgb565_t px, input logic keep);
        @(posedge clk);
        #1;
        vin_vs   = vs;
        vin_de   = de;
        vin_data = px;
        exp_de   = keep;
        exp_data = model_pixel(px, algorithm_sel);
        if (keep) begin
            kept_count++;
        end
    endtask

    task automatic pick_setup();
        int sx;
        int sy;
        sx = 0;
        sy = 0;
        end_x = xcoord_t'(FRAME_W);
        end_y = ycoord_t'(FRAME_H);
        if (rand_window) begin
            sx    = int'($urandom % 20);
            sy    = int'($urandom % 9);
            end_x = xcoord_t'(sx + 1 + int'($urandom % (FRAME_W - sx)));
            end_y = ycoord_t'(sy + 1 + int'($urandom % (FRAME_H - sy)));
        end
        start_x = xcoord_t'(sx);
        start_y = ycoord_t'(sy);
        shift_x = rand_shift ? 2'($urandom) : 2'd0;
        shift_y = rand_shift ? 2'($urandom) : 2'd0;
        case (algo_mode)
            0:       algorithm_sel = ALGO_BYPASS;
            1:       algorithm_sel = ALGO_GRAY;
            default: algorithm_sel = algo_t'(1'($urandom));
        endcase
    endtask

    // vertical blanking, then the given number of active line cycles
    task automatic send_frame(input int active);
        rgb565_t px;
        for (int i = 0; i < VS_CYCLES; i++) begin
            drive(1'b1, 1'b0, 16'($urandom), 1'b0);
            if (i == 0) begin
                pick_setup();
            end
        end
        for (int c = 0; c < active; c++) begin
            px = 16'($urandom);
            if (c % LINE_CYCLES < FRAME_W) begin
                drive(1'b0, 1'b1, px, is_kept(c % LINE_CYCLES, c / LINE_CYCLES));
            end else begin
                drive(1'b0, 1'b0, px, 1'b0);
            end
        end
    endtask

    // vs held high so that reset has to keep vp_vs low on its own
    task automatic pulse_reset(input int n);
        rst_n  = 1'b0;
        vin_vs = 1'b1;
        vin_de = 1'b0;
        exp_de = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
        rst_n = 1'b1;
    endtask

    task automatic run_test(input logic [8*16-1:0] name, input bit win, input bit shift,
                            input int algo, input bit cut);
        int err_before;
        test_name   = name;
        rand_window = win;
        rand_shift  = shift;
        algo_mode   = algo;
        kept_count  = 0;
        err_before  = errors;
        if (cut) begin
            // full window, so the pixels cut off by the reset are all kept ones
            rand_window = 1'b0;
            rand_shift  = 1'b0;
            // stop inside line 5 while pixels are still in the pipeline
            send_frame(5 * LINE_CYCLES + 10);
            pulse_reset(RESET_CYCLES);
            rand_window = win;
            rand_shift  = shift;
        end
        repeat (FRAMES) begin
            send_frame(FRAME_H * LINE_CYCLES);
        end
        for (int i = 0; i < 4 * `VP_LATENCY && pending != 0; i++) begin
            @(posedge clk);
            #1;
        end
        if (errors != err_before || pending != 0) begin
            failed_tests++;
            $display("test %0s: %0d checks failed, %0d pixels never came out",
                     name, errors - err_before, pending);
        end else begin
            $display("test %0s: ok, %0d pixels checked", name, kept_count);
        end
    endtask

    initial begin
        seed_ret      = $urandom(32'h9d0a);
        vin_vs        = 1'b1;
        vin_de        = 1'b0;
        vin_data      = '0;
        start_x       = '0;
        end_x         = xcoord_t'(FRAME_W);
        start_y       = '0;
        end_y         = ycoord_t'(FRAME_H);
        shift_x       = 2'd0;
        shift_y       = 2'd0;
        algorithm_sel = ALGO_BYPASS;
        exp_de        = 1'b0;
        exp_data      = '0;
        test_name     = "reset";
        rand_window   = 1'b0;
        rand_shift    = 1'b0;
        algo_mode     = 0;
        cycles        = 0;
        kept_count    = 0;
        failed_tests  = 0;
        pulse_reset(RESET_CYCLES);

        run_test("bypass_full", 1'b0, 1'b0, 0, 1'b0);
        run_test("crop_window", 1'b1, 1'b0, 0, 1'b0);
        run_test("decimation", 1'b1, 1'b1, 0, 1'b0);
        run_test("grayscale", 1'b0, 1'b0, 1, 1'b0);
        run_test("sync_latency", 1'b1, 1'b1, 2, 1'b0);
        run_test("reset_recovery", 1'b1, 1'b1, 2, 1'b1);

        $display("tests run %0d, tests with errors %0d, failed checks %0d",
                 NUM_TESTS, failed_tests, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
vp_pkg.sv
pixel_delay.sv
pixel_locator.sv
crop_decimator.sv
color_proc.sv
video_proc.sv
vp_checker.sv
tb_video_proc.sv

// ==== run.sh ====
#!/bin/sh
# build and run the video_proc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_video_proc -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_video_proc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
exit 1
